// ==== hw/rvx_pkg.sv ====
/*
 * rvx_pkg
 * Shared widths, operation codes and the command, result and
 * sequencer state types of the integer execute slice.
 */

package rvx_pkg;

    localparam int XLEN    = 64;
    localparam int NREGS   = 32;
    localparam int REG_AW  = 5;
    localparam int IMM_W   = 16;
    localparam int SHAMT_W = 6;

    typedef enum logic [2:0] {
        OP_LI  = 3'd0,
        OP_ADD = 3'd1,
        OP_SUB = 3'd2,
        OP_AND = 3'd3,
        OP_OR  = 3'd4,
        OP_XOR = 3'd5,
        OP_SLL = 3'd6,
        OP_SRL = 3'd7
    } exec_op_e;

    // 34 bits
    typedef struct packed {
        exec_op_e            op;
        logic [REG_AW-1:0]   rd;
        logic [REG_AW-1:0]   rs1;
        logic [REG_AW-1:0]   rs2;
        logic [IMM_W-1:0]    imm;
    } exec_cmd_t;

    // 69 bits
    typedef struct packed {
        logic [REG_AW-1:0]   rd;
        logic [XLEN-1:0]     data;
    } exec_rsp_t;

    typedef enum logic [1:0] {
        S_IDLE  = 2'd0,
        S_EXEC  = 2'd1,
        S_SHIFT = 2'd2,
        S_WB    = 2'd3
    } fsm_state_e;

endpackage

// ==== hw/dffram_3a1w2r.sv ====
/*
 * dffram_3a1w2r
 * Flip-flop register array with three address ports.
 * Port A writes a whole word at the clock edge, ports B and C
 * read combinationally through AND-OR row muxes.
 */

`timescale 1ns/1ps

module dffram_3a1w2r
    import rvx_pkg::*;
#(
    parameter int RAM_WIDTH = XLEN,
    parameter int RAM_DEPTH = NREGS
) (
    input  logic                 clk,
    input  logic                 arst_n,

    // Write port
    input  logic [REG_AW-1:0]    addra,
    input  logic                 wea,
    input  logic [RAM_WIDTH-1:0] dina,

    // Read ports
    input  logic [REG_AW-1:0]    addrb,
    input  logic [REG_AW-1:0]    addrc,
    output logic [RAM_WIDTH-1:0] doutb,
    output logic [RAM_WIDTH-1:0] doutc
);

    logic [RAM_DEPTH-1:0][RAM_WIDTH-1:0] rows;
    logic [RAM_DEPTH-1:0]                sel_a;
    logic [RAM_DEPTH-1:0]                sel_b;
    logic [RAM_DEPTH-1:0]                sel_c;

    // Binary address to one-hot row select
    always_comb begin
        for (int i = 0; i < RAM_DEPTH; i++) begin
            sel_a[i] = (addra == REG_AW'(i));
            sel_b[i] = (addrb == REG_AW'(i));
            sel_c[i] = (addrc == REG_AW'(i));
        end
    end

    // One enabled word per row
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rows <= '0;
        end else begin
            for (int i = 0; i < RAM_DEPTH; i++) begin
                if (wea && sel_a[i]) begin
                    rows[i] <= dina;
                end
            end
        end
    end

    // Unselected rows contribute zero to the OR
    always_comb begin
        doutb = '0;
        doutc = '0;
        for (int i = 0; i < RAM_DEPTH; i++) begin
            doutb = doutb | (rows[i] & {RAM_WIDTH{sel_b[i]}});
            doutc = doutc | (rows[i] & {RAM_WIDTH{sel_c[i]}});
        end
    end

    a_write_in_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        wea |-> (32'(addra) < RAM_DEPTH)
    );

endmodule

// ==== hw/shift_counter.sv ====
/*
 * shift_counter
 * Down counter for the bit-serial shifter. Loaded with the shift
 * amount, decremented per shift step, last flags a count of zero.
 */

`timescale 1ns/1ps

module shift_counter
    import rvx_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               load,
    input  logic               step,
    input  logic [SHAMT_W-1:0] amount,
    output logic               last
);

    logic [SHAMT_W-1:0] count;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (load) begin
            count <= amount;
        end else if (step) begin
            count <= count - 1'b1;
        end
    end

    assign last = (count == '0);

    // Sequencer must stop stepping once the count is spent
    a_no_step_at_zero: assert property (
        @(posedge clk) disable iff (!arst_n)
        step |-> (count != '0)
    );

endmodule

// ==== hw/exec_alu.sv ====
/*
 * exec_alu
 * Integer ALU of the execute slice. Immediate, add, sub and the
 * bitwise ops are combinational, the logical shifts run one bit
 * per step in a shift register filled with zero.
 */

`timescale 1ns/1ps

module exec_alu
    import rvx_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n,
    input  exec_op_e         op,
    input  logic [XLEN-1:0]  a,
    input  logic [XLEN-1:0]  b,
    input  logic [IMM_W-1:0] imm,
    input  logic             load,
    input  logic             step,
    output logic [XLEN-1:0]  result
);

    logic [XLEN-1:0] shreg;
    logic [XLEN-1:0] shreg_nxt;
    logic [XLEN-1:0] imm_ext;

    assign imm_ext = {{(XLEN - IMM_W){1'b0}}, imm};

    // One bit position per step
    always_comb begin
        if (op == OP_SRL) begin
            shreg_nxt = {1'b0, shreg[XLEN-1:1]};
        end else begin
            shreg_nxt = {shreg[XLEN-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shreg <= '0;
        end else if (load) begin
            shreg <= a;
        end else if (step) begin
            shreg <= shreg_nxt;
        end
    end

    always_comb begin
        case (op)
            OP_LI:   result = imm_ext;
            OP_ADD:  result = a + b;
            OP_SUB:  result = a - b;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_SLL,
            OP_SRL:  result = shreg;
            default: result = '0;
        endcase
    end

endmodule

// ==== hw/exec_seq_fsm.sv ====
/*
 * exec_seq_fsm
 * Command sequencer of the execute slice. Holds one accepted command,
 * drives the operand reads, runs the bit-serial shift loop and issues
 * the register write back together with a one-cycle done pulse.
 */

`timescale 1ns/1ps

module exec_seq_fsm
    import rvx_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,

    input  logic              cmd_valid,
    input  exec_cmd_t         cmd,
    output logic              busy,

    output logic [REG_AW-1:0] rs1_addr,
    output logic [REG_AW-1:0] rs2_addr,
    output exec_op_e          op,
    output logic [IMM_W-1:0]  imm,
    output logic              alu_load,
    output logic              shift_step,
    output logic              cnt_load,
    input  logic              cnt_last,
    input  logic [XLEN-1:0]   alu_result,

    output logic              wr_en,
    output logic [REG_AW-1:0] wr_addr,
    output logic              done,
    output exec_rsp_t         rsp
);

    fsm_state_e state;
    fsm_state_e state_nxt;
    exec_cmd_t  cmd_q;
    logic       is_shift;

    assign is_shift = (cmd_q.op == OP_SLL) || (cmd_q.op == OP_SRL);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_q <= '0;
        end else if (state == S_IDLE && cmd_valid) begin
            cmd_q <= cmd;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:  if (cmd_valid) state_nxt = S_EXEC;
            S_EXEC:  state_nxt = is_shift ? S_SHIFT : S_WB;
            S_SHIFT: if (cnt_last) state_nxt = S_WB;
            S_WB:    state_nxt = S_IDLE;
            default: state_nxt = S_IDLE;
        endcase
    end

    assign busy       = (state != S_IDLE);
    assign rs1_addr   = cmd_q.rs1;
    assign rs2_addr   = cmd_q.rs2;
    assign op         = cmd_q.op;
    assign imm        = cmd_q.imm;

    // Operand capture and count load share the execute cycle
    assign alu_load   = (state == S_EXEC);
    assign cnt_load   = (state == S_EXEC);
    assign shift_step = (state == S_SHIFT) && !cnt_last;

    // x0 writes are dropped but the result is still reported
    assign done       = (state == S_WB);
    assign wr_en      = done && (cmd_q.rd != '0);
    assign wr_addr    = cmd_q.rd;
    assign rsp.rd     = cmd_q.rd;
    assign rsp.data   = alu_result;

    a_no_cmd_while_busy: assert property (
        @(posedge clk) disable iff (!arst_n)
        cmd_valid |-> !busy
    );

    a_done_one_cycle: assert property (
        @(posedge clk) disable iff (!arst_n)
        done |=> !done
    );

endmodule

// ==== hw/rvx_exec_top.sv ====
/*
 * rvx_exec_top
 * Integer execute slice. Joins the command sequencer, the shift
 * counter, the ALU and the flip-flop register file.
 */

`timescale 1ns/1ps

module rvx_exec_top
    import rvx_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      cmd_valid,
    input  exec_cmd_t cmd,
    output logic      busy,
    output logic      done,
    output exec_rsp_t rsp
);

    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    exec_op_e          op;
    logic [IMM_W-1:0]  imm;
    logic              alu_load;
    logic              shift_step;
    logic              cnt_load;
    logic              cnt_last;
    logic [XLEN-1:0]   alu_result;
    logic              wr_en;
    logic [REG_AW-1:0] wr_addr;

    exec_seq_fsm u_seq (
        .clk        (clk),
        .arst_n     (arst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .busy       (busy),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .op         (op),
        .imm        (imm),
        .alu_load   (alu_load),
        .shift_step (shift_step),
        .cnt_load   (cnt_load),
        .cnt_last   (cnt_last),
        .alu_result (alu_result),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .done       (done),
        .rsp        (rsp)
    );

    // Shift amount from the low bits of rs2
    shift_counter u_shcnt (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (cnt_load),
        .step   (shift_step),
        .amount (rs2_data[SHAMT_W-1:0]),
        .last   (cnt_last)
    );

    exec_alu u_alu (
        .clk    (clk),
        .arst_n (arst_n),
        .op     (op),
        .a      (rs1_data),
        .b      (rs2_data),
        .imm    (imm),
        .load   (alu_load),
        .step   (shift_step),
        .result (alu_result)
    );

    dffram_3a1w2r #(
        .RAM_WIDTH (XLEN),
        .RAM_DEPTH (NREGS)
    ) u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .addra  (wr_addr),
        .wea    (wr_en),
        .dina   (alu_result),
        .addrb  (rs1_addr),
        .addrc  (rs2_addr),
        .doutb  (rs1_data),
        .doutc  (rs2_data)
    );

endmodule

// ==== tb/tb_rvx_exec.sv ====
/*
 * tb_rvx_exec
 * Testbench of the integer execute slice. Directed and random commands
 * run against a register model, concurrent assertions check each result,
 * the done latency and the busy level.
 */

`timescale 1ns/1ps

module tb_rvx_exec
    import rvx_pkg::*;
();

    localparam int          DONE_TIMEOUT = 80;
    localparam int          RANDOM_OPS   = 200;
    localparam int unsigned SEED         = 32'h33f4_756d;

    logic      clk;
    logic      arst_n;
    logic      cmd_valid;
    exec_cmd_t cmd;
    logic      busy;
    logic      done;
    exec_rsp_t rsp;

    logic [XLEN-1:0] model_regs [NREGS];
    exec_rsp_t       exp_rsp;
    int unsigned     exp_cycles;
    int unsigned     since_accept;

    rvx_exec_top u_rvx_exec_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .done      (done),
        .rsp       (rsp)
    );

    always #2 clk = ~clk;

    // Edges since acceptance where the accepting edge counts as one
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            since_accept <= 0;
        end else if (cmd_valid && !busy) begin
            since_accept <= 1;
        end else if (busy) begin
            since_accept <= since_accept + 1;
        end
    end

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    // Architectural result of one operation
    function automatic logic [XLEN-1:0] predict_result(
        input exec_op_e         op,
        input logic [XLEN-1:0]  a,
        input logic [XLEN-1:0]  b,
        input logic [IMM_W-1:0] imm
    );
        case (op)
            OP_LI:   return XLEN'(imm);
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[SHAMT_W-1:0];
            OP_SRL:  return a >> b[SHAMT_W-1:0];
            default: return '0;
        endcase
    endfunction

    function automatic logic [REG_AW-1:0] random_reg();
        return REG_AW'($urandom);
    endfunction

    function automatic logic [REG_AW-1:0] nonzero_reg();
        return REG_AW'($urandom_range(1, NREGS - 1));
    endfunction

    task automatic run_cmd(
        input exec_op_e          op,
        input logic [REG_AW-1:0] rd,
        input logic [REG_AW-1:0] rs1,
        input logic [REG_AW-1:0] rs2,
        input logic [IMM_W-1:0]  imm
    );
        exec_cmd_t       c;
        exec_rsp_t       rsp_next;
        logic [XLEN-1:0] res;
        int              waited;
        c.op  = op;
        c.rd  = rd;
        c.rs1 = rs1;
        c.rs2 = rs2;
        c.imm = imm;
        res = predict_result(op, model_regs[rs1], model_regs[rs2], imm);
        rsp_next.rd   = rd;
        rsp_next.data = res;
        exp_rsp <= rsp_next;
        // Shifts spend amount plus one cycles in the shift loop
        if (op == OP_SLL || op == OP_SRL) begin
            exp_cycles <= 32'(model_regs[rs2][SHAMT_W-1:0]) + 3;
        end else begin
            exp_cycles <= 2;
        end
        if (rd != '0) begin
            model_regs[rd] = res;
        end
        cmd_valid <= 1'b1;
        cmd       <= c;
        @(posedge clk);
        cmd_valid <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!done && waited < DONE_TIMEOUT);
        if (done) begin
            @(posedge clk);
        end else begin
            report_error($sformatf("no done within %0d cycles for %s", DONE_TIMEOUT, op.name()));
        end
    endtask

    a_rsp_matches_model: assert property (
        @(posedge clk) disable iff (!arst_n)
        done |-> (rsp == exp_rsp)
    ) else report_mismatch($sformatf("rsp rd=%0d data=%h, model rd=%0d data=%h",
        rsp.rd, rsp.data, exp_rsp.rd, exp_rsp.data));

    a_done_latency: assert property (
        @(posedge clk) disable iff (!arst_n)
        done |-> (since_accept == exp_cycles)
    ) else report_mismatch($sformatf("done after %0d cycles, expected %0d",
        since_accept, exp_cycles));

    a_quiet_after_reset: assert property (
        @(posedge clk)
        !arst_n |=> (!busy && !done)
    ) else report_error("busy or done high after reset");

    a_busy_until_done: assert property (
        @(posedge clk) disable iff (!arst_n)
        (busy && !done) |=> busy
    ) else report_error("busy dropped before done");

    a_idle_after_done: assert property (
        @(posedge clk) disable iff (!arst_n)
        done |=> !busy
    ) else report_error("busy still high after the done cycle");

    a_no_busy_without_cmd: assert property (
        @(posedge clk) disable iff (!arst_n)
        (!busy && !cmd_valid) |=> !busy
    ) else report_error("busy rose without an accepted command");

    a_no_done_when_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        !busy |-> !done
    ) else report_error("done high while not busy");

    initial begin
        logic [REG_AW-1:0]  ra;
        logic [REG_AW-1:0]  rb;
        logic [REG_AW-1:0]  rc;
        logic [SHAMT_W-1:0] amounts [8];
        clk        = 1'b0;
        arst_n     = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = '0;
        exp_rsp    = '0;
        exp_cycles = 0;
        void'($urandom(SEED));
        for (int r = 0; r < NREGS; r++) begin
            model_regs[r] = '0;
        end
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        repeat (4) @(posedge clk);

        // Every register reads zero after reset
        for (int r = 0; r < NREGS; r++) begin
            run_cmd(OP_OR, REG_AW'(1), REG_AW'(r), '0, '0);
        end

        // Immediates, then an add that reads them back at once
        for (int n = 0; n < 8; n++) begin
            ra = nonzero_reg();
            rb = nonzero_reg();
            run_cmd(OP_LI, ra, '0, '0, IMM_W'($urandom));
            run_cmd(OP_LI, rb, '0, '0, {1'b1, 15'($urandom)});
            run_cmd(OP_ADD, nonzero_reg(), ra, rb, '0);
        end

        for (int n = 0; n < 40; n++) begin
            run_cmd(exec_op_e'(3'($urandom_range(1, 5))), random_reg(), random_reg(),
                random_reg(), '0);
        end

        amounts[0] = 6'd0;
        amounts[1] = 6'd1;
        amounts[2] = 6'd63;
        for (int i = 3; i < 8; i++) begin
            amounts[i] = SHAMT_W'($urandom);
        end
        for (int i = 0; i < 8; i++) begin
            ra = nonzero_reg();
            rb = REG_AW'(32'(ra) % 31 + 1);
            rc = REG_AW'(32'(rb) % 31 + 1);
            // Zero minus the immediate gives a full width operand
            run_cmd(OP_LI, ra, '0, '0, IMM_W'($urandom) | 16'h0001);
            run_cmd(OP_SUB, ra, '0, ra, '0);
            run_cmd(OP_LI, rb, '0, '0, {10'($urandom), amounts[i]});
            run_cmd(OP_SLL, rc, ra, rb, '0);
            run_cmd(OP_SRL, rc, ra, rb, '0);
        end

        // Results to x0 are reported but not kept
        for (int n = 0; n < 10; n++) begin
            run_cmd(exec_op_e'(3'($urandom)), '0, random_reg(), random_reg(), IMM_W'($urandom));
        end
        run_cmd(OP_OR, nonzero_reg(), '0, '0, '0);

        for (int n = 0; n < RANDOM_OPS; n++) begin
            run_cmd(exec_op_e'(3'($urandom)), random_reg(), random_reg(), random_reg(),
                IMM_W'($urandom));
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== rvx_exec.f ====
hw/rvx_pkg.sv
hw/dffram_3a1w2r.sv
hw/shift_counter.sv
hw/exec_alu.sv
hw/exec_seq_fsm.sv
hw/rvx_exec_top.sv
tb/tb_rvx_exec.sv

// ==== Makefile ====
# Verilator build of the execute slice testbench
# Override on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_rvx_exec
FILELIST  ?= rvx_exec.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SOURCES   := $(wildcard hw/*.sv) $(wildcard tb/*.sv)
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a nonzero exit status
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
